//--- hdl/rv_alu.sv
`timescale 1ns/1ps

module rv_alu
  import rv_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    exec_en,
  input  alu_op_t alu_op,
  input  word_t   a,
  input  word_t   rs2_data,
  input  word_t   imm,
  input  logic    use_imm,
  output word_t   result
);

  word_t      b;
  word_t      alu_out;
  logic [4:0] shamt;

  assign b     = use_imm ? imm : rs2_data;
  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_out = a + b;
      ALU_SUB:    alu_out = a - b;
      ALU_AND:    alu_out = a & b;
      ALU_OR:     alu_out = a | b;
      ALU_XOR:    alu_out = a ^ b;
      ALU_SLL:    alu_out = a << shamt;
      ALU_SRL:    alu_out = a >> shamt;
      // sign bit shifts in
      ALU_SRA:    alu_out = word_t'($signed(a) >>> shamt);
      ALU_SLT: begin
        alu_out = '0;
        alu_out[0] = $signed(a) < $signed(b);
      end
      ALU_PASS_B: alu_out = b;
      default:    alu_out = '0;
    endcase
  end

  // held through retire
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result <= '0;
    end else if (exec_en) begin
      result <= alu_out;
    end
  end

endmodule

//--- hdl/rv_control.sv
`timescale 1ns/1ps

module rv_control
  import rv_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic instr_valid,
  output logic instr_ready,
  output logic capture,
  output logic exec_en,
  output logic retire_valid,
  input  logic retire_ready,
  input  logic writes_rd,
  output logic wr_en
);

  core_state_t state_q;
  core_state_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (instr_valid) begin
          state_d = ST_READ;
        end
      end
      // operands are sampled during read
      ST_READ: state_d = ST_EXEC;
      ST_EXEC: state_d = ST_RETIRE;
      ST_RETIRE: begin
        if (retire_ready) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign instr_ready  = (state_q == ST_IDLE);
  assign capture      = instr_valid && instr_ready;
  assign exec_en      = (state_q == ST_EXEC);
  assign retire_valid = (state_q == ST_RETIRE);
  // register file written on the retire handshake
  assign wr_en        = retire_valid && retire_ready && writes_rd;

  a_retire_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    retire_valid && !retire_ready |=> retire_valid
  );

endmodule

//--- hdl/rv_core.sv
`timescale 1ns/1ps

module rv_core
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      instr_valid,
  output logic      instr_ready,
  input  instr_t    instr,
  output logic      retire_valid,
  input  logic      retire_ready,
  output reg_addr_t retire_rd,
  output word_t     retire_data,
  output logic      retire_illegal
);

  logic      capture;
  logic      exec_en;
  logic      wr_en;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  word_t     imm;
  logic      use_imm;
  alu_op_t   alu_op;
  logic      writes_rd;
  logic      illegal;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     result;

  rv_decoder u_decoder (
    .clk(clk), .rst_n(rst_n), .capture(capture), .instr(instr),
    .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .use_imm(use_imm),
    .alu_op(alu_op), .writes_rd(writes_rd), .illegal(illegal)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .wr_en(wr_en), .rd(rd), .wr_data(result)
  );

  rv_alu u_alu (
    .clk(clk), .rst_n(rst_n), .exec_en(exec_en), .alu_op(alu_op),
    .a(rs1_data), .rs2_data(rs2_data), .imm(imm), .use_imm(use_imm),
    .result(result)
  );

  rv_control u_control (
    .clk(clk), .rst_n(rst_n),
    .instr_valid(instr_valid), .instr_ready(instr_ready),
    .capture(capture), .exec_en(exec_en),
    .retire_valid(retire_valid), .retire_ready(retire_ready),
    .writes_rd(writes_rd), .wr_en(wr_en)
  );

  // retire payload straight from the held decode and ALU result
  assign retire_rd      = rd;
  assign retire_data    = result;
  assign retire_illegal = illegal;

endmodule

//--- hdl/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_decoder
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      capture,
  input  instr_t    instr,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output reg_addr_t rd,
  output word_t     imm,
  output logic      use_imm,
  output alu_op_t   alu_op,
  output logic      writes_rd,
  output logic      illegal
);

  instr_t     instr_q;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;
  word_t      imm_i;
  word_t      imm_shamt;
  word_t      imm_u;

  // held for the whole instruction
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      instr_q <= '0;
    end else if (capture) begin
      instr_q <= instr;
    end
  end

  assign opcode = instr_q[6:0];
  assign rd     = instr_q[11:7];
  assign funct3 = instr_q[14:12];
  assign rs1    = instr_q[19:15];
  assign rs2    = instr_q[24:20];
  assign alt    = instr_q[25 + `RV_F7_ALT];

  assign imm_i     = {{(`RV_XLEN-12){instr_q[31]}}, instr_q[31:20]};
  assign imm_shamt = {{(`RV_XLEN-5){1'b0}}, instr_q[24:20]};
  assign imm_u     = {instr_q[31:12], 12'b0};

  always_comb begin
    imm     = imm_i;
    use_imm = 1'b0;
    alu_op  = ALU_ADD;
    illegal = 1'b0;
    case (opcode)
      `RV_OP_REG: begin
        case (funct3)
          `RV_F3_ADD: alu_op = alt ? ALU_SUB : ALU_ADD;
          `RV_F3_SLL: alu_op = ALU_SLL;
          `RV_F3_SLT: alu_op = ALU_SLT;
          `RV_F3_XOR: alu_op = ALU_XOR;
          `RV_F3_SR:  alu_op = alt ? ALU_SRA : ALU_SRL;
          `RV_F3_OR:  alu_op = ALU_OR;
          `RV_F3_AND: alu_op = ALU_AND;
          // sltu is not implemented
          default:    illegal = 1'b1;
        endcase
      end
      `RV_OP_IMM: begin
        use_imm = 1'b1;
        case (funct3)
          `RV_F3_ADD: alu_op = ALU_ADD;
          `RV_F3_SLL: begin
            alu_op = ALU_SLL;
            imm    = imm_shamt;
          end
          `RV_F3_SLT: alu_op = ALU_SLT;
          `RV_F3_XOR: alu_op = ALU_XOR;
          `RV_F3_SR: begin
            alu_op = alt ? ALU_SRA : ALU_SRL;
            imm    = imm_shamt;
          end
          `RV_F3_OR:  alu_op = ALU_OR;
          `RV_F3_AND: alu_op = ALU_AND;
          default:    illegal = 1'b1;
        endcase
      end
      `RV_OP_LUI: begin
        use_imm = 1'b1;
        imm     = imm_u;
        alu_op  = ALU_PASS_B;
      end
      default: illegal = 1'b1;
    endcase
  end

  // x0 is never written
  assign writes_rd = !illegal && (rd != '0);

endmodule

//--- hdl/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0]   word_t;
  typedef logic [`RV_XLEN-1:0]   instr_t;
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    // lui
    ALU_PASS_B
  } alu_op_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_EXEC,
    ST_RETIRE
  } core_state_t;

endpackage

//--- hdl/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  logic      wr_en,
  input  reg_addr_t rd,
  input  word_t     wr_data
);

  localparam int NREGS = 2 ** $bits(reg_addr_t);

  // entry 0 is cleared on reset and never written
  word_t regs [NREGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (rd != '0)) begin
      regs[rd] <= wr_data;
    end
  end

  // operands sampled every cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rs1_data <= '0;
      rs2_data <= '0;
    end else begin
      rs1_data <= (rs1 == '0) ? '0 : regs[rs1];
      rs2_data <= (rs2 == '0) ? '0 : regs[rs2];
    end
  end

  // decoder must suppress writes to x0
  a_no_x0_write: assert property (
    @(posedge clk) disable iff (!rst_n) wr_en |-> (rd != '0)
  );

endmodule

//--- include/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath and register file sizes
`define RV_XLEN    32
`define RV_NREGS   32
`define RV_REG_AW  5

// major opcodes kept in this core
`define RV_OP_REG  7'b0110011
`define RV_OP_IMM  7'b0010011
`define RV_OP_LUI  7'b0110111

// funct3 codes shared by OP and OP-IMM
`define RV_F3_ADD  3'b000
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_XOR  3'b100
`define RV_F3_SR   3'b101
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111

// bit of funct7 that picks sub and sra
`define RV_F7_ALT  5

`endif

//--- project.f
+incdir+include
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_control.sv
hdl/rv_core.sv
test/clock_gen.sv
test/rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --assert -f project.f --top-module rv_core_tb -o rv_core_sim \
  && sim_out=$(./obj_dir/rv_core_sim) \
  && echo "$sim_out" \
  && echo "$sim_out" | grep -qx "Test OK" \
  && echo "simulation passed" \
  || { echo "$sim_out"; echo "simulation failed"; exit 1; }

//--- test/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
  output logic clk,
  output logic rst_n
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #50;
      clk = ~clk;
    end
  end

  // released just after the eighth rising edge
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

//--- test/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_tb
  import rv_pkg::*;
();

  localparam logic [6:0] F7_ALT = 7'b1 << `RV_F7_ALT;

  logic      clk;
  logic      rst_n;
  logic      instr_valid;
  logic      instr_ready;
  instr_t    instr;
  logic      retire_valid;
  logic      retire_ready;
  reg_addr_t retire_rd;
  word_t     retire_data;
  logic      retire_illegal;

  // stimulus table, one entry per row
  string     names[$];
  instr_t    instrs[$];
  reg_addr_t exp_rds[$];
  word_t     exp_datas[$];
  logic      exp_ills[$];

  int cycles = 0;
  int cycle_limit = 100000;

  clock_gen u_clk (.clk(clk), .rst_n(rst_n));

  rv_core UUT (
    .clk(clk), .rst_n(rst_n),
    .instr_valid(instr_valid), .instr_ready(instr_ready), .instr(instr),
    .retire_valid(retire_valid), .retire_ready(retire_ready),
    .retire_rd(retire_rd), .retire_data(retire_data), .retire_illegal(retire_illegal)
  );

  function automatic instr_t reg_instr(input logic [2:0] f3, input logic alt,
                                       input reg_addr_t rd, input reg_addr_t rs1,
                                       input reg_addr_t rs2);
    return {(alt ? F7_ALT : 7'b0), rs2, rs1, f3, rd, `RV_OP_REG};
  endfunction

  function automatic instr_t imm_instr(input logic [2:0] f3, input reg_addr_t rd,
                                       input reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, `RV_OP_IMM};
  endfunction

  function automatic instr_t lui_instr(input reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, `RV_OP_LUI};
  endfunction

  task automatic add_row(input string name, input instr_t ins, input reg_addr_t rd,
                         input word_t data, input logic ill);
    names.push_back(name);
    instrs.push_back(ins);
    exp_rds.push_back(rd);
    exp_datas.push_back(data);
    exp_ills.push_back(ill);
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("mismatch %s: expected %h actual %h", name, expected, actual);
      $display("Test FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t expected,
                           input reg_addr_t actual);
    if (actual !== expected) begin
      $display("mismatch %s: expected %0d actual %0d", name, expected, actual);
      $display("Test FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("mismatch %s: expected %b actual %b", name, expected, actual);
      $display("Test FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic run_row(input int idx);
    string       name;
    reg_addr_t   rd_seen;
    word_t       data_seen;
    logic        ill_seen;
    int unsigned stall;
    name        = names[idx];
    instr       = instrs[idx];
    instr_valid = 1'b1;
    while (!instr_ready) begin
      @(posedge clk);
      #1;
    end
    // transfer edge
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
    instr       = '1;
    while (!retire_valid) begin
      check_flag({name, " instr_ready busy"}, 1'b0, instr_ready);
      @(posedge clk);
      #1;
    end
    rd_seen   = retire_rd;
    data_seen = retire_data;
    ill_seen  = retire_illegal;
    stall     = $urandom % 4;
    repeat (stall) begin
      @(posedge clk);
      #1;
      check_flag({name, " retire_valid stall"}, 1'b1, retire_valid);
      check_flag({name, " instr_ready stall"}, 1'b0, instr_ready);
      check_reg({name, " rd stall"}, rd_seen, retire_rd);
      check_word({name, " data stall"}, data_seen, retire_data);
      check_flag({name, " illegal stall"}, ill_seen, retire_illegal);
    end
    retire_ready = 1'b1;
    @(posedge clk);
    #1;
    retire_ready = 1'b0;
    check_flag({name, " retire_valid after"}, 1'b0, retire_valid);
    check_reg({name, " rd"}, exp_rds[idx], rd_seen);
    // data of an illegal instruction carries no meaning
    if (!exp_ills[idx]) begin
      check_word({name, " data"}, exp_datas[idx], data_seen);
    end
    check_flag({name, " illegal"}, exp_ills[idx], ill_seen);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Test FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    instr_valid  = 1'b0;
    instr        = '0;
    retire_ready = 1'b0;
    void'($urandom(44));

    // register setup
    add_row("lui x1", lui_instr(5'd1, 20'h12345), 5'd1, 32'h1234_5000, 1'b0);
    add_row("addi x1", imm_instr(`RV_F3_ADD, 5'd1, 5'd1, 12'h678), 5'd1, 32'h1234_5678, 1'b0);
    add_row("lui x2", lui_instr(5'd2, 20'hFFFFF), 5'd2, 32'hFFFF_F000, 1'b0);
    add_row("addi x2 neg", imm_instr(`RV_F3_ADD, 5'd2, 5'd2, 12'hFF0), 5'd2, 32'hFFFF_EFF0, 1'b0);
    add_row("addi x3", imm_instr(`RV_F3_ADD, 5'd3, 5'd0, 12'h064), 5'd3, 32'h0000_0064, 1'b0);
    add_row("addi x4 neg", imm_instr(`RV_F3_ADD, 5'd4, 5'd0, 12'hFFB), 5'd4, 32'hFFFF_FFFB, 1'b0);
    // R-type
    add_row("add", reg_instr(`RV_F3_ADD, 1'b0, 5'd5, 5'd1, 5'd3), 5'd5, 32'h1234_56DC, 1'b0);
    add_row("sub", reg_instr(`RV_F3_ADD, 1'b1, 5'd6, 5'd3, 5'd1), 5'd6, 32'hEDCB_A9EC, 1'b0);
    add_row("and", reg_instr(`RV_F3_AND, 1'b0, 5'd7, 5'd1, 5'd2), 5'd7, 32'h1234_4670, 1'b0);
    add_row("or", reg_instr(`RV_F3_OR, 1'b0, 5'd8, 5'd1, 5'd3), 5'd8, 32'h1234_567C, 1'b0);
    add_row("xor", reg_instr(`RV_F3_XOR, 1'b0, 5'd9, 5'd1, 5'd2), 5'd9, 32'hEDCB_B988, 1'b0);
    add_row("slt neg<pos", reg_instr(`RV_F3_SLT, 1'b0, 5'd10, 5'd4, 5'd3), 5'd10, 32'h1, 1'b0);
    add_row("slt pos<neg", reg_instr(`RV_F3_SLT, 1'b0, 5'd11, 5'd3, 5'd4), 5'd11, 32'h0, 1'b0);
    add_row("sll", reg_instr(`RV_F3_SLL, 1'b0, 5'd12, 5'd1, 5'd3), 5'd12, 32'h2345_6780, 1'b0);
    add_row("srl", reg_instr(`RV_F3_SR, 1'b0, 5'd13, 5'd2, 5'd3), 5'd13, 32'h0FFF_FEFF, 1'b0);
    add_row("sra", reg_instr(`RV_F3_SR, 1'b1, 5'd14, 5'd2, 5'd3), 5'd14, 32'hFFFF_FEFF, 1'b0);
    // I-type
    add_row("xori", imm_instr(`RV_F3_XOR, 5'd15, 5'd1, 12'hFFF), 5'd15, 32'hEDCB_A987, 1'b0);
    add_row("ori", imm_instr(`RV_F3_OR, 5'd16, 5'd3, 12'h700), 5'd16, 32'h0000_0764, 1'b0);
    add_row("andi", imm_instr(`RV_F3_AND, 5'd17, 5'd1, 12'hF00), 5'd17, 32'h1234_5600, 1'b0);
    add_row("slti true", imm_instr(`RV_F3_SLT, 5'd18, 5'd4, 12'hFFC), 5'd18, 32'h1, 1'b0);
    add_row("slti false", imm_instr(`RV_F3_SLT, 5'd19, 5'd3, 12'hFFF), 5'd19, 32'h0, 1'b0);
    add_row("slli", imm_instr(`RV_F3_SLL, 5'd20, 5'd1, 12'h008), 5'd20, 32'h3456_7800, 1'b0);
    add_row("srli", imm_instr(`RV_F3_SR, 5'd21, 5'd2, 12'h00C), 5'd21, 32'h000F_FFFE, 1'b0);
    add_row("srai", imm_instr(`RV_F3_SR, 5'd22, 5'd2, 12'h40C), 5'd22, 32'hFFFF_FFFE, 1'b0);
    // x0 stays zero
    add_row("lui x0", lui_instr(5'd0, 20'hABCDE), 5'd0, 32'hABCD_E000, 1'b0);
    add_row("add from x0", reg_instr(`RV_F3_ADD, 1'b0, 5'd23, 5'd0, 5'd3), 5'd23, 32'h64, 1'b0);
    // unknown opcode with rd field 5
    add_row("illegal", 32'h0000_02FF, 5'd5, 32'h0, 1'b1);
    add_row("x5 kept", imm_instr(`RV_F3_ADD, 5'd24, 5'd5, 12'h000), 5'd24, 32'h1234_56DC, 1'b0);

    // reset, then at most 8 cycles per row
    cycle_limit = 8 + names.size() * 8 + 20;

    wait (rst_n);
    @(posedge clk);
    #1;
    check_flag("reset instr_ready", 1'b1, instr_ready);
    check_flag("reset retire_valid", 1'b0, retire_valid);

    for (int i = 0; i < names.size(); i++) begin
      run_row(i);
    end

    $display("Test OK");
    $finish;
  end

endmodule
